/* design/pixel_track_config.svh */
`ifndef PIXEL_TRACK_CONFIG_SVH
`define PIXEL_TRACK_CONFIG_SVH

// screen coordinate widths
`define PT_X_W 11
`define PT_Y_W 10

// accumulators, pixel count and divider words
`define PT_SUM_W 32

// registered stages inside color_convert
`define PT_CONV_LAT 3
// input pixel strobe to registered mask bit
`define PT_MASK_LAT 4

// settings after reset: green channel, window 0..15
`define PT_DEF_SEL 3'd0
`define PT_DEF_LO 4'd0
`define PT_DEF_HI 4'd15

`endif

/* design/pixel_track_pkg.sv */
`include "pixel_track_config.svh"

package pixel_track_pkg;

  // pixel position on screen
  typedef struct packed {
    logic [`PT_X_W-1:0] x;
    logic [`PT_Y_W-1:0] y;
  } pix_coord_t;

  // raw camera word, red in the top bits
  typedef struct packed {
    logic [4:0] r;
    logic [5:0] g;
    logic [4:0] b;
  } rgb565_t;

  typedef struct packed {
    logic [7:0] r;
    logic [7:0] g;
    logic [7:0] b;
  } rgb888_t;

  // cr and cb carry the +128 offset, so they read as unsigned
  typedef struct packed {
    logic [7:0] y;
    logic [7:0] cr;
    logic [7:0] cb;
  } ycc_t;

  // conversion output, both color spaces side by side
  typedef struct packed {
    logic       valid;
    pix_coord_t coord;
    rgb888_t    rgb;
    ycc_t       ycc;
  } conv_beat_t;

  typedef struct packed {
    logic       valid;
    pix_coord_t coord;
    logic [7:0] channel;
    logic       mask;
  } mask_beat_t;

  // threshold bounds are in units of 16
  typedef struct packed {
    logic [2:0] sel;
    logic [3:0] lo;
    logic [3:0] hi;
  } track_cfg_t;

  typedef struct packed {
    logic [`PT_X_W-1:0] x;
    logic [`PT_Y_W-1:0] y;
  } centroid_t;

endpackage

/* design/color_convert.sv */
`timescale 1ns/100ps
`include "pixel_track_config.svh"

module color_convert (
  input  logic                        clk_pixel,
  input  logic                        recent_reset,
  input  logic                        pixel_valid_i,
  input  pixel_track_pkg::rgb565_t    pixel_i,
  input  pixel_track_pkg::pix_coord_t coord_i,
  output pixel_track_pkg::conv_beat_t beat_o
);
  import pixel_track_pkg::*;

  rgb888_t rgb_in;
  logic signed [9:0] r_s;
  logic signed [9:0] g_s;
  logic signed [9:0] b_s;
  // products, order is y(r,g,b) then cr(r,g,b) then cb(r,g,b)
  logic signed [17:0] prod_q [9];
  // y, cr, cb sums with the rounding constant already in
  logic signed [19:0] sum_q [3];
  logic signed [19:0] y_round;
  logic signed [19:0] cr_round;
  logic signed [19:0] cb_round;
  ycc_t ycc_q;
  // side pipe that keeps the beat aligned with the math
  logic [`PT_CONV_LAT-1:0] valid_q;
  pix_coord_t coord_q [`PT_CONV_LAT];
  rgb888_t rgb_q [`PT_CONV_LAT];

  // 565 to 888, low bits filled with zeros
  always_comb begin
    rgb_in.r = {pixel_i.r, 3'b000};
    rgb_in.g = {pixel_i.g, 2'b00};
    rgb_in.b = {pixel_i.b, 3'b000};
  end

  // positive operands for the signed multiplies
  assign r_s = {2'b00, rgb_in.r};
  assign g_s = {2'b00, rgb_in.g};
  assign b_s = {2'b00, rgb_in.b};

  // stage 1: coefficient products
  always_ff @(posedge clk_pixel) begin
    prod_q[0] <= 18'sd66 * r_s;
    prod_q[1] <= 18'sd129 * g_s;
    prod_q[2] <= 18'sd25 * b_s;
    prod_q[3] <= 18'sd112 * r_s;
    prod_q[4] <= -18'sd94 * g_s;
    prod_q[5] <= -18'sd18 * b_s;
    prod_q[6] <= -18'sd38 * r_s;
    prod_q[7] <= -18'sd74 * g_s;
    prod_q[8] <= 18'sd112 * b_s;
  end

  // stage 2: sums plus half an lsb of the final result
  always_ff @(posedge clk_pixel) begin
    sum_q[0] <= prod_q[0] + prod_q[1] + prod_q[2] + 20'sd128;
    sum_q[1] <= prod_q[3] + prod_q[4] + prod_q[5] + 20'sd128;
    sum_q[2] <= prod_q[6] + prod_q[7] + prod_q[8] + 20'sd128;
  end

  // stage 3: scale down and add offsets, chroma shifts keep the sign
  always_comb begin
    y_round  = (sum_q[0] >>> 8) + 20'sd16;
    cr_round = (sum_q[1] >>> 8) + 20'sd128;
    cb_round = (sum_q[2] >>> 8) + 20'sd128;
  end

  always_ff @(posedge clk_pixel) begin
    ycc_q.y  <= y_round[7:0];
    ycc_q.cr <= cr_round[7:0];
    ycc_q.cb <= cb_round[7:0];
  end

  always_ff @(posedge clk_pixel) begin
    if (recent_reset) begin
      valid_q <= '0;
    end else begin
      valid_q <= {valid_q[`PT_CONV_LAT-2:0], pixel_valid_i};
    end
  end

  always_ff @(posedge clk_pixel) begin
    coord_q[0] <= coord_i;
    rgb_q[0]   <= rgb_in;
    for (int i = 1; i < `PT_CONV_LAT; i++) begin
      coord_q[i] <= coord_q[i-1];
      rgb_q[i]   <= rgb_q[i-1];
    end
  end

  always_comb begin
    beat_o.valid = valid_q[`PT_CONV_LAT-1];
    beat_o.coord = coord_q[`PT_CONV_LAT-1];
    beat_o.rgb   = rgb_q[`PT_CONV_LAT-1];
    beat_o.ycc   = ycc_q;
  end

endmodule

/* design/channel_mask.sv */
`timescale 1ns/100ps

module channel_mask (
  input  logic                        clk_pixel,
  input  logic                        recent_reset,
  input  pixel_track_pkg::conv_beat_t beat_i,
  input  pixel_track_pkg::track_cfg_t cfg_i,
  output pixel_track_pkg::mask_beat_t beat_o
);
  import pixel_track_pkg::*;

  logic [7:0] channel;
  logic [7:0] lo_bound;
  logic [7:0] hi_bound;
  logic       in_window;
  logic       valid_q;
  pix_coord_t coord_q;
  logic [7:0] channel_q;
  logic       mask_q;

  // codes 3 and 7 are unused and read as zero
  always_comb begin
    case (cfg_i.sel)
      3'd0:    channel = beat_i.rgb.g;
      3'd1:    channel = beat_i.rgb.r;
      3'd2:    channel = beat_i.rgb.b;
      3'd4:    channel = beat_i.ycc.y;
      3'd5:    channel = beat_i.ycc.cr;
      3'd6:    channel = beat_i.ycc.cb;
      default: channel = 8'd0;
    endcase
  end

  // bounds are thresholds times 16, both ends count
  assign lo_bound  = {cfg_i.lo, 4'b0000};
  assign hi_bound  = {cfg_i.hi, 4'b0000};
  assign in_window = (channel >= lo_bound) && (channel <= hi_bound);

  always_ff @(posedge clk_pixel) begin
    if (recent_reset) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= beat_i.valid;
    end
  end

  always_ff @(posedge clk_pixel) begin
    coord_q   <= beat_i.coord;
    channel_q <= channel;
    mask_q    <= in_window;
  end

  always_comb begin
    beat_o.valid   = valid_q;
    beat_o.coord   = coord_q;
    beat_o.channel = channel_q;
    beat_o.mask    = mask_q;
  end

endmodule

/* design/centroid_unit.sv */
`timescale 1ns/100ps
`include "pixel_track_config.svh"

module centroid_unit (
  input  logic                        clk_pixel,
  input  logic                        recent_reset,
  input  pixel_track_pkg::mask_beat_t beat_i,
  input  logic                        tabulate_i,
  output pixel_track_pkg::centroid_t  quot_o,
  output logic                        done_o,
  output logic                        busy_o
);
  localparam int STEP_W = $clog2(`PT_SUM_W);

  logic                  hit;
  logic [`PT_SUM_W-1:0] x_ext;
  logic [`PT_SUM_W-1:0] y_ext;
  logic [`PT_SUM_W-1:0] sum_x_q;
  logic [`PT_SUM_W-1:0] sum_y_q;
  logic [`PT_SUM_W-1:0] cnt_q;
  logic                  start;
  logic                  busy_q;
  logic [STEP_W-1:0]     step_q;
  logic                  last_step;
  // dividend regs fill up with quotient bits from the bottom
  logic [`PT_SUM_W-1:0] dx_q;
  logic [`PT_SUM_W-1:0] dy_q;
  logic [`PT_SUM_W-1:0] rx_q;
  logic [`PT_SUM_W-1:0] ry_q;
  logic [`PT_SUM_W-1:0] den_q;
  logic [`PT_SUM_W-1:0] dx_next;
  logic [`PT_SUM_W-1:0] dy_next;
  logic [`PT_SUM_W-1:0] rx_next;
  logic [`PT_SUM_W-1:0] ry_next;

  // one restoring step, returns {remainder, dividend with new quotient bit}
  function automatic logic [2*`PT_SUM_W-1:0] div_step(
    input logic [`PT_SUM_W-1:0] rem,
    input logic [`PT_SUM_W-1:0] dvd,
    input logic [`PT_SUM_W-1:0] den
  );
    logic [`PT_SUM_W:0]   trial;
    logic [`PT_SUM_W-1:0] rem_next;
    logic                  q_bit;
    trial    = {rem, dvd[`PT_SUM_W-1]};
    q_bit    = (trial >= {1'b0, den});
    // difference is below den, so the low word holds it exactly
    rem_next = q_bit ? (trial[`PT_SUM_W-1:0] - den) : trial[`PT_SUM_W-1:0];
    return {rem_next, dvd[`PT_SUM_W-2:0], q_bit};
  endfunction

  assign hit   = beat_i.valid && beat_i.mask;
  assign x_ext = {{(`PT_SUM_W-`PT_X_W){1'b0}}, beat_i.coord.x};
  assign y_ext = {{(`PT_SUM_W-`PT_Y_W){1'b0}}, beat_i.coord.y};

  // empty frame never starts the divider
  assign start     = tabulate_i && !busy_q && (cnt_q != '0);
  assign last_step = busy_q && (step_q == STEP_W'(`PT_SUM_W - 1));

  always_ff @(posedge clk_pixel) begin
    if (recent_reset) begin
      sum_x_q <= '0;
      sum_y_q <= '0;
      cnt_q   <= '0;
      busy_q  <= 1'b0;
      step_q  <= '0;
    end else begin
      // a beat in the tabulate cycle already belongs to the next frame
      if (tabulate_i) begin
        sum_x_q <= hit ? x_ext : '0;
        sum_y_q <= hit ? y_ext : '0;
        cnt_q   <= hit ? `PT_SUM_W'(1) : '0;
      end else if (hit) begin
        sum_x_q <= sum_x_q + x_ext;
        sum_y_q <= sum_y_q + y_ext;
        cnt_q   <= cnt_q + 1'b1;
      end
      if (start) begin
        busy_q <= 1'b1;
        step_q <= '0;
      end else if (busy_q) begin
        step_q <= step_q + 1'b1;
        if (last_step) begin
          busy_q <= 1'b0;
        end
      end
    end
  end

  always_comb begin
    {rx_next, dx_next} = div_step(rx_q, dx_q, den_q);
    {ry_next, dy_next} = div_step(ry_q, dy_q, den_q);
  end

  always_ff @(posedge clk_pixel) begin
    if (start) begin
      dx_q  <= sum_x_q;
      dy_q  <= sum_y_q;
      den_q <= cnt_q;
      rx_q  <= '0;
      ry_q  <= '0;
    end else if (busy_q) begin
      dx_q <= dx_next;
      dy_q <= dy_next;
      rx_q <= rx_next;
      ry_q <= ry_next;
    end
  end

  // final step result goes out in the same cycle as done
  always_comb begin
    quot_o.x = dx_next[`PT_X_W-1:0];
    quot_o.y = dy_next[`PT_Y_W-1:0];
  end

  assign done_o = last_step;
  assign busy_o = busy_q;

endmodule

/* design/track_control.sv */
`timescale 1ns/100ps
`include "pixel_track_config.svh"

module track_control (
  input  logic                        clk_pixel,
  input  logic                        recent_reset,
  input  logic                        frame_end_i,
  input  pixel_track_pkg::track_cfg_t cfg_i,
  input  logic                        busy_i,
  input  pixel_track_pkg::centroid_t  quot_i,
  input  logic                        done_i,
  output pixel_track_pkg::track_cfg_t cfg_o,
  output logic                        tabulate_o,
  output pixel_track_pkg::centroid_t  centroid_o,
  output logic                        centroid_valid_o
);
  import pixel_track_pkg::*;

  // frame end delay, tab_q is the last stage
  logic [`PT_MASK_LAT-2:0] fe_q;
  logic                    tab_q;
  track_cfg_t              cfg_q;
  logic                    done_q;
  centroid_t               cap_q;
  centroid_t               cent_q;
  logic                    cent_valid_q;

  always_ff @(posedge clk_pixel) begin
    if (recent_reset) begin
      fe_q         <= '0;
      tab_q        <= 1'b0;
      cfg_q        <= '{sel: `PT_DEF_SEL, lo: `PT_DEF_LO, hi: `PT_DEF_HI};
      done_q       <= 1'b0;
      cent_q       <= '0;
      cent_valid_q <= 1'b0;
    end else begin
      fe_q <= {fe_q[`PT_MASK_LAT-3:0], frame_end_i};
      // frame end lines up with the last mask beat of the frame
      // dropped while the divider still works on the previous frame
      tab_q <= fe_q[`PT_MASK_LAT-2] && !busy_i;
      // new settings switch in with tabulate even when it is dropped
      if (fe_q[`PT_MASK_LAT-2]) begin
        cfg_q <= cfg_i;
      end
      done_q       <= done_i;
      cent_valid_q <= done_q;
      if (done_q) begin
        cent_q <= cap_q;
      end
    end
  end

  // quotients are only good during done
  always_ff @(posedge clk_pixel) begin
    if (done_i) begin
      cap_q <= quot_i;
    end
  end

  assign cfg_o            = cfg_q;
  assign tabulate_o       = tab_q;
  assign centroid_o       = cent_q;
  assign centroid_valid_o = cent_valid_q;

endmodule

/* design/pixel_track_top.sv */
`timescale 1ns/100ps

module pixel_track_top (
  input  logic                        clk_pixel,
  input  logic                        recent_reset,
  input  logic                        pixel_valid_i,
  input  pixel_track_pkg::rgb565_t    pixel_i,
  input  pixel_track_pkg::pix_coord_t coord_i,
  input  logic                        frame_end_i,
  input  pixel_track_pkg::track_cfg_t cfg_i,
  output logic                        mask_valid_o,
  output pixel_track_pkg::pix_coord_t mask_coord_o,
  output logic [7:0]                  channel_o,
  output logic                        mask_o,
  output pixel_track_pkg::centroid_t  centroid_o,
  output logic                        centroid_valid_o
);
  import pixel_track_pkg::*;

  conv_beat_t conv_beat;
  mask_beat_t mask_beat;
  // settings that govern the current frame
  track_cfg_t active_cfg;
  logic       tabulate;
  centroid_t  div_quot;
  logic       div_done;
  logic       div_busy;

  // rgb565 to rgb888 and ycrcb, 3 cycles
  color_convert u_color_convert (
    .clk_pixel    (clk_pixel),
    .recent_reset (recent_reset),
    .pixel_valid_i(pixel_valid_i),
    .pixel_i      (pixel_i),
    .coord_i      (coord_i),
    .beat_o       (conv_beat)
  );

  channel_mask u_channel_mask (
    .clk_pixel   (clk_pixel),
    .recent_reset(recent_reset),
    .beat_i      (conv_beat),
    .cfg_i       (active_cfg),
    .beat_o      (mask_beat)
  );

  centroid_unit u_centroid_unit (
    .clk_pixel   (clk_pixel),
    .recent_reset(recent_reset),
    .beat_i      (mask_beat),
    .tabulate_i  (tabulate),
    .quot_o      (div_quot),
    .done_o      (div_done),
    .busy_o      (div_busy)
  );

  track_control u_track_control (
    .clk_pixel       (clk_pixel),
    .recent_reset    (recent_reset),
    .frame_end_i     (frame_end_i),
    .cfg_i           (cfg_i),
    .busy_i          (div_busy),
    .quot_i          (div_quot),
    .done_i          (div_done),
    .cfg_o           (active_cfg),
    .tabulate_o      (tabulate),
    .centroid_o      (centroid_o),
    .centroid_valid_o(centroid_valid_o)
  );

  // mask stream goes straight out
  assign mask_valid_o = mask_beat.valid;
  assign mask_coord_o = mask_beat.coord;
  assign channel_o    = mask_beat.channel;
  assign mask_o       = mask_beat.mask;

endmodule

/* testbench/clock_gen.sv */
`timescale 1ns/100ps

module clock_gen (
  output logic clk_pixel,
  output logic recent_reset
);

  // 100 ns period
  initial begin
    clk_pixel = 1'b0;
    forever #50 clk_pixel = ~clk_pixel;
  end

  // high over the first 4 rising edges, dropped on a falling edge
  initial begin
    recent_reset = 1'b1;
    repeat (4) @(posedge clk_pixel);
    @(negedge clk_pixel);
    recent_reset = 1'b0;
  end

endmodule

/* testbench/pixel_track_tb.sv */
`timescale 1ns/100ps

module pixel_track_tb;
  import pixel_track_pkg::*;

  // whole run needs about 1200 cycles, limit leaves a wide margin
  localparam int CYCLE_LIMIT = 20000;

  logic       clk_pixel;
  logic       recent_reset;
  logic       pixel_valid_i;
  rgb565_t    pixel_i;
  pix_coord_t coord_i;
  logic       frame_end_i;
  track_cfg_t cfg_i;
  logic       mask_valid_o;
  pix_coord_t mask_coord_o;
  logic [7:0] channel_o;
  logic       mask_o;
  centroid_t  centroid_o;
  logic       centroid_valid_o;

  integer seed = 40033;
  int error_count = 0;
  int check_count = 0;
  int cycle_count = 0;

  // means of the last frame that had masked pixels
  centroid_t last_centroid = '0;

  // stimulus and expected responses for one stream
  rgb565_t    stim_pix[$];
  pix_coord_t stim_coord[$];
  logic [7:0] exp_chan[$];
  logic       exp_mask[$];

  clock_gen u_clock_gen (
    .clk_pixel   (clk_pixel),
    .recent_reset(recent_reset)
  );

  pixel_track_top DUT (
    .clk_pixel       (clk_pixel),
    .recent_reset    (recent_reset),
    .pixel_valid_i   (pixel_valid_i),
    .pixel_i         (pixel_i),
    .coord_i         (coord_i),
    .frame_end_i     (frame_end_i),
    .cfg_i           (cfg_i),
    .mask_valid_o    (mask_valid_o),
    .mask_coord_o    (mask_coord_o),
    .channel_o       (channel_o),
    .mask_o          (mask_o),
    .centroid_o      (centroid_o),
    .centroid_valid_o(centroid_valid_o)
  );

  always @(posedge clk_pixel) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Test FAILED");
      $finish;
    end
  end

  task automatic check_val(input string what, input logic [31:0] got,
                           input logic [31:0] exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("** Error at %0t: %s is %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  // 565 expanded to 888, then the YCrCb equations with 8-bit wrap
  function automatic logic [7:0] model_channel(input rgb565_t pix, input logic [2:0] sel);
    int r;
    int g;
    int b;
    int y;
    int cr;
    int cb;
    r  = int'(pix.r) * 8;
    g  = int'(pix.g) * 4;
    b  = int'(pix.b) * 8;
    y  = ((66 * r + 129 * g + 25 * b + 128) >>> 8) + 16;
    cr = ((112 * r - 94 * g - 18 * b + 128) >>> 8) + 128;
    cb = ((-38 * r - 74 * g + 112 * b + 128) >>> 8) + 128;
    case (sel)
      3'd0:    return g[7:0];
      3'd1:    return r[7:0];
      3'd2:    return b[7:0];
      3'd4:    return y[7:0];
      3'd5:    return cr[7:0];
      3'd6:    return cb[7:0];
      default: return 8'd0;
    endcase
  endfunction

  function automatic logic model_mask(input logic [7:0] chan, input track_cfg_t cfg);
    return (int'(chan) >= int'(cfg.lo) * 16) && (int'(chan) <= int'(cfg.hi) * 16);
  endfunction

  task automatic add_pixel_exp(input rgb565_t pix, input pix_coord_t coord,
                               input logic [7:0] chan, input logic mask);
    stim_pix.push_back(pix);
    stim_coord.push_back(coord);
    exp_chan.push_back(chan);
    exp_mask.push_back(mask);
  endtask

  task automatic add_pixel(input rgb565_t pix, input pix_coord_t coord, input track_cfg_t cfg);
    logic [7:0] chan;
    chan = model_channel(pix, cfg.sel);
    add_pixel_exp(pix, coord, chan, model_mask(chan, cfg));
  endtask

  task automatic add_random_pixels(input int n, input track_cfg_t cfg);
    rgb565_t    pix;
    pix_coord_t coord;
    for (int i = 0; i < n; i++) begin
      pix     = 16'($random(seed));
      coord.x = 11'($random(seed));
      coord.y = 10'($random(seed));
      add_pixel(pix, coord, cfg);
    end
  endtask

  // back to back beats, each output checked 4 falling edges after its drive
  task automatic run_stream();
    int n;
    n = stim_pix.size();
    for (int t = 0; t < n + 4; t++) begin
      @(negedge clk_pixel);
      if (t >= 4) begin
        check_val("mask_valid_o", mask_valid_o, 1'b1);
        check_val("mask_coord_o", mask_coord_o, stim_coord[t-4]);
        check_val("channel_o", channel_o, exp_chan[t-4]);
        check_val("mask_o", mask_o, exp_mask[t-4]);
      end
      if (t < n) begin
        pixel_valid_i = 1'b1;
        pixel_i       = stim_pix[t];
        coord_i       = stim_coord[t];
      end else begin
        pixel_valid_i = 1'b0;
      end
    end
    stim_pix.delete();
    stim_coord.delete();
    exp_chan.delete();
    exp_mask.delete();
  endtask

  task automatic pulse_frame_end();
    @(negedge clk_pixel);
    frame_end_i = 1'b1;
    @(negedge clk_pixel);
    frame_end_i = 1'b0;
  endtask

  // divider finishes 38 cycles after the frame end
  task automatic switch_settings(input track_cfg_t cfg);
    @(negedge clk_pixel);
    cfg_i = cfg;
    pulse_frame_end();
    repeat (45) @(negedge clk_pixel);
  endtask

  task automatic wait_centroid(input int limit, output logic seen);
    seen = 1'b0;
    for (int i = 0; i < limit && !seen; i++) begin
      @(negedge clk_pixel);
      if (centroid_valid_o) begin
        seen = 1'b1;
      end
    end
  endtask

  task automatic test_reset_state();
    check_val("mask_valid_o after reset", mask_valid_o, 1'b0);
    check_val("centroid_valid_o after reset", centroid_valid_o, 1'b0);
    check_val("centroid_o after reset", centroid_o, '0);
    // defaults: green, window 0..15
    add_random_pixels(8, '{sel: 3'd0, lo: 4'd0, hi: 4'd15});
    run_stream();
  endtask

  task automatic test_channel_values();
    track_cfg_t cfg;
    for (int s = 0; s < 8; s++) begin
      cfg = '{sel: 3'(s), lo: 4'd3, hi: 4'd12};
      switch_settings(cfg);
      add_random_pixels(40, cfg);
      run_stream();
    end
  endtask

  // red channel is r times 8, window 64..160
  task automatic test_threshold_window();
    logic [4:0] red [6];
    logic       in_window [6];
    pix_coord_t coord;
    red       = '{5'd7, 5'd8, 5'd9, 5'd19, 5'd20, 5'd21};
    in_window = '{1'b0, 1'b1, 1'b1, 1'b1, 1'b1, 1'b0};
    switch_settings('{sel: 3'd1, lo: 4'd4, hi: 4'd10});
    for (int i = 0; i < 6; i++) begin
      coord = '{x: 11'(i * 3), y: 10'(i)};
      add_pixel_exp('{r: red[i], g: 6'($random(seed)), b: 5'($random(seed))},
                    coord, {red[i], 3'b000}, in_window[i]);
    end
    run_stream();
  endtask

  task automatic test_centroid();
    track_cfg_t cfg;
    pix_coord_t hits [5];
    int         sum_x;
    int         sum_y;
    logic       seen;
    cfg   = '{sel: 3'd1, lo: 4'd8, hi: 4'd15};
    hits  = '{'{11'd100, 10'd10}, '{11'd203, 10'd77}, '{11'd517, 10'd300},
              '{11'd640, 10'd479}, '{11'd1, 10'd2}};
    sum_x = 0;
    sum_y = 0;
    switch_settings(cfg);
    // red 160 is inside 128..240, red 16 is not
    for (int i = 0; i < 5; i++) begin
      add_pixel('{r: 5'd20, g: 6'd45, b: 5'd3}, hits[i], cfg);
      add_pixel('{r: 5'd2, g: 6'd63, b: 5'd31}, '{x: 11'd2000, y: 10'd1000}, cfg);
      sum_x += hits[i].x;
      sum_y += hits[i].y;
    end
    last_centroid.x = 11'(sum_x / 5);
    last_centroid.y = 10'(sum_y / 5);
    run_stream();
    pulse_frame_end();
    wait_centroid(60, seen);
    if (!seen) begin
      error_count++;
      $display("centroid_valid_o never rose after the frame end of the centroid frame");
    end
    check_val("centroid_o.x", centroid_o.x, last_centroid.x);
    check_val("centroid_o.y", centroid_o.y, last_centroid.y);
  endtask

  task automatic test_empty_frame();
    pix_coord_t coord;
    logic       seen;
    for (int i = 0; i < 8; i++) begin
      coord = '{x: 11'($random(seed)), y: 10'($random(seed))};
      add_pixel('{r: 5'd0, g: 6'($random(seed)), b: 5'($random(seed))}, coord,
                '{sel: 3'd1, lo: 4'd8, hi: 4'd15});
    end
    run_stream();
    pulse_frame_end();
    wait_centroid(60, seen);
    if (seen) begin
      error_count++;
      $display("centroid_valid_o rose after a frame with no masked pixels");
    end
    check_val("centroid_o held", centroid_o, last_centroid);
  endtask

  task automatic test_frame_boundary();
    track_cfg_t cfg_old;
    track_cfg_t cfg_new;
    cfg_old = '{sel: 3'd1, lo: 4'd8, hi: 4'd15};
    cfg_new = '{sel: 3'd2, lo: 4'd0, hi: 4'd4};
    add_random_pixels(10, cfg_old);
    run_stream();
    // new value on the input in mid frame, old one still active
    @(negedge clk_pixel);
    cfg_i = cfg_new;
    add_random_pixels(10, cfg_old);
    run_stream();
    pulse_frame_end();
    add_random_pixels(10, cfg_new);
    run_stream();
    repeat (45) @(negedge clk_pixel);
  endtask

  initial begin
    pixel_valid_i = 1'b0;
    pixel_i       = '0;
    coord_i       = '0;
    frame_end_i   = 1'b0;
    cfg_i         = '{sel: 3'd0, lo: 4'd0, hi: 4'd15};
    @(negedge recent_reset);
    @(negedge clk_pixel);
    test_reset_state();
    test_channel_values();
    test_threshold_window();
    test_centroid();
    test_empty_frame();
    test_frame_boundary();
    $display("Summary: %0d checks, %0d errors", check_count, error_count);
    if (error_count == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

/* pixel_track.f */
+incdir+design
design/pixel_track_pkg.sv
design/color_convert.sv
design/channel_mask.sv
design/centroid_unit.sv
design/track_control.sv
design/pixel_track_top.sv
testbench/clock_gen.sv
testbench/pixel_track_tb.sv

/* Makefile */
SIM = obj_dir/pixel_track_sim

.PHONY: compile run clean

compile:
	verilator --binary --timing -Wno-fatal -f pixel_track.f \
	  --top-module pixel_track_tb -o pixel_track_sim

run: compile
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf obj_dir
